//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing -Wall
TOP      := tb_pcs_rx_monitor
DUT_TOP  := pcs_rx_monitor_top
FLIST    := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
verilog/pcs_rx_pkg.sv
verilog/block_sync.sv
verilog/ber_monitor.sv
verilog/pcs_status_regs.sv
verilog/pcs_rx_monitor_top.sv
test/tb_pcs_rx_monitor.sv

//--- test/tb_pcs_rx_monitor.sv
`timescale 1ns/1ps

module tb_pcs_rx_monitor;

        localparam int          LOCK_COUNT      = 64;
        localparam int          UNLOCK_LIMIT    = 16;
        localparam int          HI_BER_LIMIT    = 8;    // Kept below UNLOCK_LIMIT so a BER burst keeps lock
        localparam int          BER_WINDOW      = 100;
        localparam int          CLK_PERIOD      = 8;
        localparam int          SETTLE_CYCLES   = 4;
        localparam int          AXI_TIMEOUT     = 50;
        localparam int          NUM_ROWS        = 13;

        typedef enum int {M_INIT, M_TEST, M_HI_BER} ber_state_t;

        typedef struct packed {
                logic [15:0]    headers;
                logic [15:0]    bad_first;
                logic           test_mode;
                logic           exp_lock;
                logic           exp_hi_ber;
                logic [15:0]    exp_count;
        } row_t;

        logic                   clock;
        logic                   reset;
        logic [1:0]             header;
        logic                   header_valid;
        pcs_rx_pkg::axil_req_t  axil_req;
        pcs_rx_pkg::axil_rsp_t  axil_rsp;
        logic                   block_lock;
        logic                   hi_ber;
        integer                 seed;
        string                  test_name;

        logic                   m_lock;         // Reference model of the link, updated per header
        int                     m_run;
        int                     m_bad;
        ber_state_t             m_state;
        int                     m_timer;
        int                     m_ber_cnt;
        int                     m_events;
        logic                   m_test_mode;

        string row_name [NUM_ROWS] = '{
                "reset_state", "hunt_partial", "hunt_restart", "lock_gain",
                "hi_ber_raise", "hi_ber_hold", "hi_ber_clear", "below_limit",
                "count_restart", "test_mode_burst", "test_mode_off", "lock_hold",
                "lock_loss"
        };

        // Columns are headers, bad headers first, test mode, expected lock, hi_ber and count
        row_t rows [NUM_ROWS] = '{
                '{16'd0,   16'd0,  1'b0, 1'b0, 1'b0, 16'd0},
                '{16'd40,  16'd0,  1'b0, 1'b0, 1'b0, 16'd0},
                '{16'd64,  16'd1,  1'b0, 1'b0, 1'b0, 16'd0},
                '{16'd1,   16'd0,  1'b0, 1'b1, 1'b0, 16'd0},
                '{16'd50,  16'd8,  1'b0, 1'b1, 1'b1, 16'd1},
                '{16'd49,  16'd0,  1'b0, 1'b1, 1'b1, 16'd1},
                '{16'd101, 16'd0,  1'b0, 1'b1, 1'b0, 16'd1},
                '{16'd100, 16'd7,  1'b0, 1'b1, 1'b0, 16'd1},
                '{16'd100, 16'd7,  1'b0, 1'b1, 1'b0, 16'd1},
                '{16'd100, 16'd12, 1'b1, 1'b1, 1'b0, 16'd0},
                '{16'd50,  16'd8,  1'b0, 1'b1, 1'b1, 16'd1},
                '{16'd15,  16'd15, 1'b0, 1'b1, 1'b1, 16'd1},
                '{16'd1,   16'd1,  1'b0, 1'b0, 1'b0, 16'd1}
        };

        pcs_rx_monitor_top #(
                .LOCK_COUNT     (LOCK_COUNT),
                .UNLOCK_LIMIT   (UNLOCK_LIMIT),
                .HI_BER_LIMIT   (HI_BER_LIMIT),
                .BER_WINDOW     (BER_WINDOW)
        ) i_pcs_rx_monitor_top (
                .i_clock        (clock),
                .i_reset        (reset),
                .i_header       (header),
                .i_header_valid (header_valid),
                .i_axil         (axil_req),
                .o_axil         (axil_rsp),
                .o_block_lock   (block_lock),
                .o_hi_ber       (hi_ber)
        );

        initial
        begin
                clock = 1'b0;
                forever #(CLK_PERIOD / 2) clock = ~clock;
        end

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display(">>> FAIL");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic check_value(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
                assert (actual === expected)
                else
                begin
                        $display("MISMATCH test %s %s expected %0h actual %0h",
                                 test_name, what, expected, actual);
                        abort_run("A DUT output differs from the reference model");
                end
        endtask

        function automatic void model_reset();
                m_lock      = 1'b0;
                m_run       = 0;
                m_bad       = 0;
                m_state     = M_INIT;
                m_timer     = 0;
                m_ber_cnt   = 0;
                m_events    = 0;
                m_test_mode = 1'b0;
        endfunction

        // Unlocked, m_run is the good run; locked, it is the slot in the lock window
        function automatic void model_sync(input logic bad);
                if (!m_lock)
                begin
                        m_run = bad ? 0 : m_run + 1;
                        if (m_run == LOCK_COUNT)
                        begin
                                m_lock = 1'b1;
                                m_run  = 0;
                        end
                end
                else
                begin
                        m_run++;
                        m_bad += bad;
                        if (m_bad == UNLOCK_LIMIT)
                                m_lock = 1'b0;
                        if (m_bad == UNLOCK_LIMIT || m_run == LOCK_COUNT)
                        begin
                                m_run = 0;
                                m_bad = 0;
                        end
                end
        endfunction

        function automatic void model_ber(input logic has_event, input logic bad);
                logic window_done;
                if (!m_lock || m_test_mode)
                begin
                        m_state   = M_INIT;
                        m_timer   = 0;
                        m_ber_cnt = 0;
                end
                else if (m_state == M_INIT)
                begin
                        m_state   = M_TEST;     // An event arriving in this cycle is not counted
                        m_timer   = 0;
                        m_ber_cnt = 0;
                end
                else if (has_event)
                begin
                        m_timer++;
                        window_done = (m_timer == BER_WINDOW);
                        if (window_done)
                                m_timer = 0;
                        if (m_state == M_TEST)
                        begin
                                m_ber_cnt += bad;
                                if (m_ber_cnt == HI_BER_LIMIT)
                                begin
                                        m_state = M_HI_BER;
                                        m_events++;
                                end
                                if (window_done || m_state == M_HI_BER)
                                        m_ber_cnt = 0;
                        end
                        else if (window_done)
                                m_state = M_TEST;
                end
        endfunction

        task automatic send_header(input logic bad);
                logic [31:0] rnd;
                rnd = $random(seed);
                @(negedge clock);
                if (bad)
                        header = rnd[0] ? 2'b11 : 2'b00;
                else
                        header = rnd[0] ? 2'b10 : 2'b01;
                header_valid = 1'b1;
                model_sync(bad);
                model_ber(1'b1, bad);   // Its event reaches the monitor after the lock update
        endtask

        task automatic settle();
                @(negedge clock);
                header_valid = 1'b0;
                repeat (SETTLE_CYCLES) @(negedge clock);
                model_ber(1'b0, 1'b0);
        endtask

        task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
                int wait_cycles;
                @(negedge clock);
                axil_req.awaddr  = addr;
                axil_req.awvalid = 1'b1;
                axil_req.wdata   = data;
                axil_req.wvalid  = 1'b1;
                wait_cycles = 0;
                #(CLK_PERIOD / 4);
                check_value("awready", 32'd1, axil_rsp.awready);       // No response is pending here
                check_value("wready", 32'd1, axil_rsp.wready);
                @(negedge clock);
                while (!axil_rsp.bvalid)
                begin
                        if (wait_cycles == AXI_TIMEOUT)
                                abort_run("Timeout waiting for the AXI4-Lite write response");
                        wait_cycles++;
                        @(negedge clock);
                end
                axil_req.awvalid = 1'b0;
                axil_req.wvalid  = 1'b0;
                check_value("bresp", 32'd0, axil_rsp.bresp);
                m_events = 0;                   // Any write clears the event count
                if (addr == pcs_rx_pkg::REG_CONTROL)
                        m_test_mode = data[0];
        endtask

        task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
                int wait_cycles;
                @(negedge clock);
                axil_req.araddr  = addr;
                axil_req.arvalid = 1'b1;
                wait_cycles = 0;
                #(CLK_PERIOD / 4);
                check_value("arready", 32'd1, axil_rsp.arready);
                @(negedge clock);
                while (!axil_rsp.rvalid)
                begin
                        if (wait_cycles == AXI_TIMEOUT)
                                abort_run("Timeout waiting for the AXI4-Lite read data");
                        wait_cycles++;
                        @(negedge clock);
                end
                axil_req.arvalid = 1'b0;
                data = axil_rsp.rdata;
                check_value("rresp", 32'd0, axil_rsp.rresp);
        endtask

        task automatic check_row(input row_t row);
                logic [31:0] rd;
                logic        m_hi_ber;
                m_hi_ber = (m_state == M_HI_BER);
                assert (row.exp_lock === m_lock && row.exp_hi_ber === m_hi_ber &&
                        row.exp_count == m_events)
                else
                        abort_run($sformatf("Row %s of the stimulus table disagrees with the model",
                                            test_name));
                check_value("block_lock", m_lock, block_lock);
                check_value("hi_ber", m_hi_ber, hi_ber);
                axil_read(pcs_rx_pkg::REG_STATUS, rd);
                check_value("status", {30'b0, m_hi_ber, m_lock}, rd);
                axil_read(pcs_rx_pkg::REG_HI_BER_COUNT, rd);
                check_value("event_count", m_events, rd);
                axil_read(pcs_rx_pkg::REG_CONTROL, rd);
                check_value("control", m_test_mode, rd);
        endtask

        initial
        begin
                seed            = 32'h3fed;
                reset           = 1'b1;
                header          = 2'b00;
                header_valid    = 1'b0;
                axil_req        = '0;
                axil_req.bready = 1'b1;         // The master always takes responses at once
                axil_req.rready = 1'b1;
                test_name       = "reset";
                model_reset();
                repeat (10) @(negedge clock);
                reset = 1'b0;
                for (int r = 0; r < NUM_ROWS; r++)
                begin
                        test_name = row_name[r];
                        if (rows[r].test_mode !== m_test_mode)
                        begin
                                axil_write(pcs_rx_pkg::REG_CONTROL, {31'b0, rows[r].test_mode});
                                settle();
                        end
                        for (int h = 0; h < rows[r].headers; h++)
                                send_header(h < rows[r].bad_first);
                        settle();
                        check_row(rows[r]);
                end
                $display(">>> PASS");
                $finish;
        end

endmodule

//--- verilog/ber_monitor.sv
`timescale 1ns/1ps

module ber_monitor
#(
        parameter int                   HI_BER_LIMIT    = 16,
        parameter int                   BER_WINDOW      = 125
)
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        input  pcs_rx_pkg::sh_event_t   i_sh_event,
        input  logic                    i_block_lock,
        input  logic                    i_test_mode,
        output logic                    o_hi_ber
);

        localparam int                  TMR_W           = $clog2(BER_WINDOW + 1);
        localparam int                  CNT_W           = $clog2(HI_BER_LIMIT + 1);
        localparam logic [TMR_W-1:0]    TMR_LAST        = TMR_W'(BER_WINDOW - 1);
        localparam logic [CNT_W-1:0]    CNT_LAST        = CNT_W'(HI_BER_LIMIT - 1);

        typedef enum logic [2:0] {
                ST_INIT         = 3'b001,
                ST_TEST         = 3'b010,
                ST_HI_BER       = 3'b100
        } state_t;

        state_t                         state, next_state;
        logic [TMR_W-1:0]               win_timer;      // Headers seen in the current window
        logic [CNT_W-1:0]               ber_cnt;        // Bad headers seen in the current window
        logic                           hold;
        logic                           bad;
        logic                           window_end;
        logic                           limit_hit;

        assign hold       = !i_block_lock || i_test_mode;
        assign bad        = i_sh_event.valid && !i_sh_event.sh_ok;
        assign window_end = i_sh_event.valid && (win_timer == TMR_LAST);
        assign limit_hit  = bad && (ber_cnt == CNT_LAST);     // This bad header reaches the limit

        always_comb
        begin
                next_state = state;
                case (state)
                        ST_INIT:        next_state = ST_TEST;
                        ST_TEST:        if (limit_hit) next_state = ST_HI_BER;
                        ST_HI_BER:      if (window_end) next_state = ST_TEST;
                        default:        next_state = ST_INIT;
                endcase
                if (hold)
                        next_state = ST_INIT;                   // No lock or test mode parks the monitor
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        state <= ST_INIT;
                else
                        state <= next_state;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset || hold || state == ST_INIT || window_end)
                        win_timer <= '0;
                else if (i_sh_event.valid)
                        win_timer <= win_timer + 1'b1;
        end

        // Counting happens only in TEST and restarts on entry, so HI_BER always leaves a clean count
        always_ff @(posedge i_clock)
        begin
                if (i_reset || hold || state != ST_TEST || window_end)
                        ber_cnt <= '0;
                else if (bad)
                        ber_cnt <= ber_cnt + 1'b1;
        end

        assign o_hi_ber = (state == ST_HI_BER);

endmodule

//--- verilog/block_sync.sv
`timescale 1ns/1ps

module block_sync
#(
        parameter int                   LOCK_COUNT      = 64,
        parameter int                   UNLOCK_LIMIT    = 16
)
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        input  logic [1:0]              i_header,
        input  logic                    i_header_valid,
        output pcs_rx_pkg::sh_event_t   o_sh_event,
        output logic                    o_block_lock
);

        localparam int                  HDR_W           = $clog2(LOCK_COUNT + 1);
        localparam int                  BAD_W           = $clog2(UNLOCK_LIMIT + 1);
        localparam logic [HDR_W-1:0]    HDR_LAST        = HDR_W'(LOCK_COUNT - 1);
        localparam logic [BAD_W-1:0]    BAD_LAST        = BAD_W'(UNLOCK_LIMIT - 1);

        logic                           sh_ok;
        logic [HDR_W-1:0]               hdr_cnt;        // Good run while unlocked, window slot when locked
        logic [BAD_W-1:0]               bad_cnt;        // Bad headers in the current lock window

        assign sh_ok = i_header[1] ^ i_header[0];       // Only 01 and 10 are legal sync headers

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        o_sh_event <= '0;
                else
                begin
                        o_sh_event.valid <= i_header_valid;
                        o_sh_event.sh_ok <= sh_ok;
                end
        end

        // Acquisition needs an unbroken run of good headers
        // Once locked, the same counter walks through windows of LOCK_COUNT headers
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_block_lock <= 1'b0;
                        hdr_cnt      <= '0;
                        bad_cnt      <= '0;
                end
                else if (i_header_valid)
                begin
                        if (!o_block_lock)
                        begin
                                bad_cnt <= '0;
                                if (!sh_ok)
                                        hdr_cnt <= '0;                  // Any bad header restarts the run
                                else if (hdr_cnt == HDR_LAST)
                                begin
                                        o_block_lock <= 1'b1;
                                        hdr_cnt      <= '0;
                                end
                                else
                                        hdr_cnt <= hdr_cnt + 1'b1;
                        end
                        else if (!sh_ok && bad_cnt == BAD_LAST)
                        begin
                                o_block_lock <= 1'b0;                   // Too many errors, go back to hunting
                                hdr_cnt      <= '0;
                                bad_cnt      <= '0;
                        end
                        else if (hdr_cnt == HDR_LAST)
                        begin
                                hdr_cnt <= '0;                          // Window complete with lock kept
                                bad_cnt <= '0;
                        end
                        else
                        begin
                                hdr_cnt <= hdr_cnt + 1'b1;
                                bad_cnt <= bad_cnt + BAD_W'(!sh_ok);
                        end
                end
        end

endmodule

//--- verilog/pcs_rx_monitor_top.sv
`timescale 1ns/1ps

module pcs_rx_monitor_top
#(
        parameter int                   LOCK_COUNT      = 64,
        parameter int                   UNLOCK_LIMIT    = 16,
        parameter int                   HI_BER_LIMIT    = 16,
        parameter int                   BER_WINDOW      = 125
)
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        input  logic [1:0]              i_header,
        input  logic                    i_header_valid,
        input  pcs_rx_pkg::axil_req_t   i_axil,
        output pcs_rx_pkg::axil_rsp_t   o_axil,
        output logic                    o_block_lock,
        output logic                    o_hi_ber
);

        pcs_rx_pkg::sh_event_t          sh_event;
        pcs_rx_pkg::pcs_status_t        status;
        logic                           block_lock;
        logic                           hi_ber;
        logic                           test_mode;

        block_sync #(
                .LOCK_COUNT     (LOCK_COUNT),
                .UNLOCK_LIMIT   (UNLOCK_LIMIT)
        ) i_block_sync (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_header       (i_header),
                .i_header_valid (i_header_valid),
                .o_sh_event     (sh_event),
                .o_block_lock   (block_lock)
        );

        ber_monitor #(
                .HI_BER_LIMIT   (HI_BER_LIMIT),
                .BER_WINDOW     (BER_WINDOW)
        ) i_ber_monitor (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_sh_event     (sh_event),
                .i_block_lock   (block_lock),
                .i_test_mode    (test_mode),
                .o_hi_ber       (hi_ber)
        );

        assign status = '{block_lock: block_lock, hi_ber: hi_ber};

        pcs_status_regs i_pcs_status_regs (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_axil         (i_axil),
                .i_status       (status),
                .o_axil         (o_axil),
                .o_test_mode    (test_mode)
        );

        assign o_block_lock = block_lock;
        assign o_hi_ber     = hi_ber;

endmodule

//--- verilog/pcs_rx_pkg.sv
package pcs_rx_pkg;

        // One entry per received sync header, as seen by the BER monitor
        typedef struct packed {
                logic           valid;          // A header arrived this cycle
                logic           sh_ok;          // Header was 01 or 10
        } sh_event_t;

        typedef struct packed {
                logic           block_lock;
                logic           hi_ber;
        } pcs_status_t;

        typedef struct packed {
                logic [3:0]     awaddr;
                logic           awvalid;
                logic [31:0]    wdata;
                logic           wvalid;
                logic           bready;
                logic [3:0]     araddr;
                logic           arvalid;
                logic           rready;
        } axil_req_t;

        typedef struct packed {
                logic           awready;
                logic           wready;
                logic           bvalid;
                logic [1:0]     bresp;
                logic           arready;
                logic           rvalid;
                logic [31:0]    rdata;
                logic [1:0]     rresp;
        } axil_rsp_t;

        localparam logic [3:0] REG_CONTROL      = 4'h0;    // Bit 0 is test mode
        localparam logic [3:0] REG_STATUS       = 4'h4;    // Bit 0 lock, bit 1 high BER
        localparam logic [3:0] REG_HI_BER_COUNT = 4'h8;    // Saturating high-BER event count

endpackage

//--- verilog/pcs_status_regs.sv
`timescale 1ns/1ps

module pcs_status_regs
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        input  pcs_rx_pkg::axil_req_t   i_axil,
        input  pcs_rx_pkg::pcs_status_t i_status,
        output pcs_rx_pkg::axil_rsp_t   o_axil,
        output logic                    o_test_mode
);

        logic                           wr_accept;
        logic                           rd_accept;
        logic                           bvalid;
        logic                           rvalid;
        logic [31:0]                    rdata;
        logic [31:0]                    rd_value;
        logic                           test_mode;
        logic                           hi_ber_q;       // Previous hi_ber for edge detection
        logic [15:0]                    event_cnt;

        // Address and data must arrive together, and only one write response is outstanding
        assign wr_accept = i_axil.awvalid && i_axil.wvalid && !bvalid;
        assign rd_accept = i_axil.arvalid && !rvalid;

        always_comb
        begin
                case (i_axil.araddr)
                        pcs_rx_pkg::REG_CONTROL:
                                rd_value = {31'b0, test_mode};
                        pcs_rx_pkg::REG_STATUS:
                                rd_value = {30'b0, i_status.hi_ber, i_status.block_lock};
                        pcs_rx_pkg::REG_HI_BER_COUNT:
                                rd_value = {16'b0, event_cnt};
                        default:
                                rd_value = '0;          // Unmapped addresses read as zero
                endcase
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        bvalid <= 1'b0;
                else if (wr_accept)
                        bvalid <= 1'b1;
                else if (i_axil.bready)
                        bvalid <= 1'b0;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        rvalid <= 1'b0;
                else if (rd_accept)
                        rvalid <= 1'b1;
                else if (i_axil.rready)
                        rvalid <= 1'b0;
        end

        always_ff @(posedge i_clock)
        begin
                if (rd_accept)
                        rdata <= rd_value;              // Sampled at acceptance and held until rready
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        test_mode <= 1'b0;
                else if (wr_accept && i_axil.awaddr == pcs_rx_pkg::REG_CONTROL)
                        test_mode <= i_axil.wdata[0];
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        hi_ber_q  <= 1'b0;
                        event_cnt <= '0;
                end
                else
                begin
                        hi_ber_q <= i_status.hi_ber;
                        if (wr_accept)
                                event_cnt <= '0;        // Any write clears the count
                        else if (i_status.hi_ber && !hi_ber_q && event_cnt != 16'hffff)
                                event_cnt <= event_cnt + 1'b1;
                end
        end

        assign o_axil = '{
                awready: wr_accept,
                wready:  wr_accept,
                bvalid:  bvalid,
                bresp:   2'b00,
                arready: rd_accept,
                rvalid:  rvalid,
                rdata:   rdata,
                rresp:   2'b00
        };

        assign o_test_mode = test_mode;

endmodule
